// ==== Bender.yml ====
package:
  name: mips_bus_port

sources:
  - verilog/mips_bus_pkg.sv
  - verilog/mem_req_if.sv
  - verilog/lane_decoder.sv
  - verilog/load_formatter.sv
  - verilog/access_sequencer.sv
  - verilog/mips_bus_port.sv
  - target: test
    files:
      - verif/mips_bus_port_assert.sv
      - verif/tb_mips_bus_port.sv

// ==== all.f ====
verilog/mips_bus_pkg.sv
verilog/mem_req_if.sv
verilog/lane_decoder.sv
verilog/load_formatter.sv
verilog/access_sequencer.sv
verilog/mips_bus_port.sv
verif/mips_bus_port_assert.sv
verif/tb_mips_bus_port.sv

// ==== verif/mips_bus_port_assert.sv ====
// ========================================
// Avalon master protocol checks on mips_bus_port
// ========================================
`default_nettype none

module mips_bus_port_assert
	import mips_bus_pkg::*;
#(
	parameter int addr_width = 32
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  read,
	input logic                  write,
	input logic                  done,
	input logic                  waitrequest,
	input logic [addr_width-1:0] address,
	input logic [lane_count-1:0] byteenable,
	input logic [word_width-1:0] writedata
);

	int fail_count = 0;

	assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			$error("read and write high together");
			fail_count++;
		end

	// a stalled transfer keeps its address and payload
	assert property (@(posedge clk) disable iff (reset)
		(read || write) && waitrequest |=> $stable(address) && $stable(byteenable)
			&& $stable(writedata))
		else begin
			$error("Avalon signals changed while waitrequest was high");
			fail_count++;
		end

	assert property (@(posedge clk) $fell(reset) |-> !read && !write && !done)
		else begin
			$error("strobe or done high in the first cycle after reset");
			fail_count++;
		end

endmodule

bind mips_bus_port mips_bus_port_assert #(.addr_width(addr_width)) u_assert (.*);

`default_nettype wire

// ==== verif/tb_mips_bus_port.sv ====
// ========================================
// directed tests against a 64-word memory model
// waitrequest is random unless a test holds it high
// ========================================
`default_nettype none

module tb_mips_bus_port;
	import mips_bus_pkg::*;

	localparam int timeout_cycles = 200;
	localparam logic [31:0] fetch_pc = 32'h0000_00f0;

	logic        clk = 1'b0;
	logic        reset;
	logic        step;
	logic [31:0] pc;
	logic        mem_en;
	logic [5:0]  op;
	logic [31:0] data_addr;
	logic [31:0] store_data;
	logic [31:0] rt_value;
	logic        ready;
	logic        done;
	logic [31:0] instruction;
	logic [31:0] load_data;
	logic [31:0] address;
	logic        read;
	logic        write;
	logic        waitrequest;
	logic [31:0] writedata;
	logic [3:0]  byteenable;
	logic [31:0] readdata;
	logic        hold_wait;
	logic        wait_rand;
	logic [3:0]  read_lanes;
	integer      rnd;
	integer      wait_draw;
	integer      seed = 32'h5bd8_c99d;
	logic [31:0] mem [64];
	logic [31:0] model [64];

	mips_bus_port #(.addr_width(32)) DUT (.*);

	always #4 clk = ~clk;

	// word-addressed memory slave
	assign waitrequest = hold_wait | wait_rand;
	assign readdata = mem[address[7:2]];

	// drawn on the rising edge, applied on the falling edge
	always @(posedge clk) begin
		wait_draw = $random(seed);
	end

	always @(negedge clk) begin
		wait_rand <= wait_draw[0];
	end

	always @(posedge clk) begin
		if (write && !waitrequest) begin
			for (int k = 0; k < 4; k++) begin
				if (byteenable[k]) begin
					mem[address[7:2]][k*8 +: 8] <= writedata[k*8 +: 8];
				end
			end
		end
		if (read && !waitrequest) begin
			read_lanes <= byteenable;
		end
	end

	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h9e37_79b1) ^ 32'h80c0_40a0 ^ 32'(idx);
	endfunction

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	// stop as soon as a bound protocol assertion has fired
	always @(negedge clk) begin
		assert (DUT.u_assert.fail_count == 0) else begin
			$display("a bound Avalon protocol assertion failed");
			stop_run();
		end
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic issue_step(input logic [31:0] p, input logic en, input logic [5:0] o,
		input logic [31:0] a, input logic [31:0] sd, input logic [31:0] rt);
		@(negedge clk);
		check_word("ready", {31'b0, ready}, 32'h1);
		check_word("done", {31'b0, done}, 32'h0);
		step = 1'b1;
		pc = p;
		mem_en = en;
		op = o;
		data_addr = a;
		store_data = sd;
		rt_value = rt;
		@(negedge clk);
		step = 1'b0;
		// fetch strobe one cycle after the accepting edge
		check_word("read", {31'b0, read}, 32'h1);
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("timed out waiting for done");
				stop_run();
			end
		end
		check_word("ready", {31'b0, ready}, 32'h1);
	endtask

	// expected load result from the reference memory
	function automatic logic [31:0] expected_load(input logic [5:0] o, input logic [31:0] a,
		input logic [31:0] rt);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] res;
		int          off;
		w = model[a[7:2]];
		off = a[1:0];
		b = w[off*8 +: 8];
		h = w[(a[1] ? 16 : 0) +: 16];
		res = rt;
		case (o)
			op_lb:   res = {{24{b[7]}}, b};
			op_lbu:  res = {24'h0, b};
			op_lh:   res = {{16{h[15]}}, h};
			op_lhu:  res = {16'h0, h};
			op_lwl: begin
				for (int k = 0; k <= off; k++) begin
					res[(3-off+k)*8 +: 8] = w[k*8 +: 8];
				end
			end
			op_lwr: begin
				for (int k = off; k < 4; k++) begin
					res[(k-off)*8 +: 8] = w[k*8 +: 8];
				end
			end
			default: res = w;
		endcase
		return res;
	endfunction

	// lanes a load must enable, from the opcode and byte offset
	function automatic logic [3:0] expected_lanes(input logic [5:0] o, input logic [1:0] off);
		logic [3:0] be;
		for (int k = 0; k < 4; k++) begin
			case (o)
				op_lb, op_lbu: be[k] = (k == off);
				op_lh, op_lhu: be[k] = ((k / 2) == off[1]);
				op_lwl:        be[k] = (k <= off);
				op_lwr:        be[k] = (k >= off);
				default:       be[k] = 1'b1;
			endcase
		end
		return be;
	endfunction

	task automatic data_access(input logic [5:0] o, input logic [31:0] a,
		input logic [31:0] sd, input logic [31:0] rt);
		issue_step(fetch_pc, 1'b1, o, a, sd, rt);
		wait_done();
		check_word("instruction", instruction, fill_word(fetch_pc[7:2]));
	endtask

	task automatic load_check(input logic [5:0] o, input logic [31:0] a, input logic [31:0] rt);
		data_access(o, a, 32'h0, rt);
		check_word("byteenable", {28'b0, read_lanes}, {28'b0, expected_lanes(o, a[1:0])});
		check_word("load_data", load_data, expected_load(o, a, rt));
	endtask

	// store then read back the word against the lane-rule model
	task automatic store_check(input logic [5:0] o, input logic [31:0] a, input logic [31:0] sd);
		data_access(o, a, sd, 32'h0);
		case (o)
			op_sb:   model[a[7:2]][a[1:0]*8 +: 8] = sd[7:0];
			op_sh:   model[a[7:2]][(a[1] ? 16 : 0) +: 16] = sd[15:0];
			default: model[a[7:2]] = sd;
		endcase
		load_check(op_lw, {a[31:2], 2'b00}, 32'h0);
	endtask

	task automatic test_fetch_only();
		check_word("read", {31'b0, read}, 32'h0);
		check_word("write", {31'b0, write}, 32'h0);
		issue_step(32'h0000_004a, 1'b0, op_lw, 32'h0, 32'h0, 32'h0);
		wait_done();
		check_word("instruction", instruction, fill_word(18));
		check_word("byteenable", {28'b0, read_lanes}, 32'hf);
	endtask

	task automatic test_partial_access();
		for (int off = 0; off < 4; off++) begin
			rnd = $random(seed);
			store_check(op_sb, 32'h40 + off, rnd);
		end
		store_check(op_sh, 32'h50, $random(seed));
		store_check(op_sh, 32'h52, $random(seed));
		for (int off = 0; off < 4; off++) begin
			load_check(op_lb, 32'h80 + 5*off, 32'h0);
			load_check(op_lbu, 32'h80 + 5*off, 32'h0);
			load_check(op_lh, 32'h80 + 5*off, 32'h0);
			load_check(op_lhu, 32'h80 + 5*off, 32'h0);
			load_check(op_lwl, 32'h90 + 5*off, $random(seed));
			load_check(op_lwr, 32'h90 + 5*off, $random(seed));
		end
	endtask

	task automatic test_back_pressure();
		hold_wait = 1'b1;
		issue_step(32'h0000_0064, 1'b0, op_lw, 32'h0, 32'h0, 32'h0);
		repeat (20) begin
			@(negedge clk);
			assert (!done && read) else begin
				$display("step did not stall while waitrequest was held high");
				stop_run();
			end
		end
		hold_wait = 1'b0;
		wait_done();
		check_word("instruction", instruction, fill_word(25));
	endtask

	initial begin
		reset = 1'b1;
		step = 1'b0;
		pc = '0;
		mem_en = 1'b0;
		op = op_lw;
		data_addr = '0;
		store_data = '0;
		rt_value = '0;
		hold_wait = 1'b0;
		wait_rand = 1'b0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = fill_word(i);
			model[i] = fill_word(i);
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		test_fetch_only();
		store_check(op_sw, 32'h24, 32'hdead_beef);
		store_check(op_sw, 32'h30, $random(seed));
		test_partial_access();
		test_back_pressure();
		if (DUT.u_assert.fail_count != 0) begin
			$display("a bound Avalon protocol assertion failed");
			stop_run();
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/access_sequencer.sv ====
// ========================================
// one step in flight: instruction fetch, then an optional load or store
// step is ignored while ready is low; done pulses one cycle at the end
// ========================================
`default_nettype none

module access_sequencer
	import mips_bus_pkg::*;
#(
	parameter int addr_width = 32
) (
	input  logic                  clk,
	input  logic                  reset,

	// request side
	input  logic                  step,
	input  logic [addr_width-1:0] pc,
	input  logic                  mem_en,
	input  logic [op_width-1:0]   op,
	input  logic [addr_width-1:0] data_addr,
	input  logic [word_width-1:0] store_data,
	input  logic [word_width-1:0] rt_value,
	output logic                  ready,
	output logic                  done,

	// Avalon master
	output logic [addr_width-1:0] address,
	output logic                  read,
	output logic                  write,
	input  logic                  waitrequest,
	output logic [word_width-1:0] writedata,
	output logic [lane_count-1:0] byteenable,
	input  logic [word_width-1:0] readdata,

	// results
	output logic [word_width-1:0] instruction,
	output logic [word_width-1:0] load_word,
	output logic [word_width-1:0] rt_held,

	mem_req_if.seq                req
);

	localparam logic [2:0] st_idle   = 3'd0;
	localparam logic [2:0] st_fetch  = 3'd1;
	localparam logic [2:0] st_gap    = 3'd2;
	localparam logic [2:0] st_data   = 3'd3;
	localparam logic [2:0] st_finish = 3'd4;

	logic [2:0]            state;
	logic [2:0]            state_next;
	logic                  accept;
	logic                  mem_en_q;
	logic                  is_store;
	logic [addr_width-1:0] pc_q;
	logic [addr_width-1:0] addr_q;
	logic [op_width-1:0]   op_q;
	logic [word_width-1:0] store_q;
	logic [word_width-1:0] rt_q;

	// finish doubles as a ready state so back-to-back steps lose no cycle
	assign ready = (state == st_idle) || (state == st_finish);
	assign done = (state == st_finish);
	assign accept = step && ready;

	assign is_store = (op_q == op_sb) || (op_q == op_sh) || (op_q == op_sw);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			mem_en_q <= 1'b0;
		end else begin
			state <= state_next;
			if (accept) begin
				mem_en_q <= mem_en;
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle, st_finish: begin
				state_next = accept ? st_fetch : st_idle;
			end
			st_fetch: begin
				if (!waitrequest) begin
					state_next = mem_en_q ? st_gap : st_finish;
				end
			end
			st_gap: begin
				state_next = st_data;
			end
			st_data: begin
				if (!waitrequest) begin
					state_next = st_finish;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// request payload, held for the whole step
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q <= pc;
			addr_q <= data_addr;
			op_q <= op;
			store_q <= store_data;
			rt_q <= rt_value;
		end
	end

	// read data captured on the completing edge
	always_ff @(posedge clk) begin
		if ((state == st_fetch) && !waitrequest) begin
			instruction <= readdata;
		end
		if ((state == st_data) && !waitrequest && !is_store) begin
			load_word <= readdata;
		end
	end

	assign req.op = op_q;
	assign req.offset = addr_q[1:0];
	assign req.store_data = store_q;
	assign rt_held = rt_q;

	// strobes
	assign read = (state == st_fetch) || ((state == st_data) && !is_store);
	assign write = (state == st_data) && is_store;

	// both accesses are word aligned
	assign address = (state == st_fetch) ? {pc_q[addr_width-1:2], 2'b00}
		: {addr_q[addr_width-1:2], 2'b00};

	always_comb begin
		case (state)
			st_fetch: byteenable = lanes_all;
			st_data:  byteenable = req.byteenable;
			default:  byteenable = '0;
		endcase
	end

	assign writedata = (state == st_data) ? req.writedata : '0;

endmodule

`default_nettype wire

// ==== verilog/lane_decoder.sv ====
// ========================================
// byteenable and store lane placement, combinational
// halfword ops look at offset bit 1 only
// ========================================
`default_nettype none

module lane_decoder
	import mips_bus_pkg::*;
(
	mem_req_if.lanes lanes
);

	logic [word_width-1:0] byte_placed;
	logic [word_width-1:0] half_placed;

	// low byte or halfword moved up to its lane
	assign byte_placed = word_width'(lanes.store_data[7:0]) << {lanes.offset, 3'b000};
	assign half_placed = word_width'(lanes.store_data[15:0]) << {lanes.offset[1], 4'b0000};

	always_comb begin
		case (lanes.op)
			op_lb, op_lbu, op_sb: begin
				lanes.byteenable = 4'b0001 << lanes.offset;
			end
			op_lh, op_lhu, op_sh: begin
				lanes.byteenable = lanes.offset[1] ? 4'b1100 : 4'b0011;
			end
			// lanes 0 up to offset
			op_lwl: begin
				case (lanes.offset)
					2'd0:    lanes.byteenable = 4'b0001;
					2'd1:    lanes.byteenable = 4'b0011;
					2'd2:    lanes.byteenable = 4'b0111;
					default: lanes.byteenable = 4'b1111;
				endcase
			end
			// offset up to lane 3
			op_lwr: begin
				lanes.byteenable = lanes_all << lanes.offset;
			end
			default: begin
				lanes.byteenable = lanes_all;
			end
		endcase
	end

	always_comb begin
		case (lanes.op)
			op_sb:   lanes.writedata = byte_placed;
			op_sh:   lanes.writedata = half_placed;
			default: lanes.writedata = lanes.store_data;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/load_formatter.sv ====
// ========================================
// load result formatting, combinational
// LWL/LWR merge into rt_value; little endian lanes
// ========================================
`default_nettype none

module load_formatter
	import mips_bus_pkg::*;
(
	mem_req_if.fmt               fmt,
	input  logic [word_width-1:0] load_word,
	input  logic [word_width-1:0] rt_value,
	output logic [word_width-1:0] load_data
);

	logic [word_width-1:0] byte_shifted;
	logic [word_width-1:0] half_shifted;
	logic [7:0]            sel_byte;
	logic [15:0]           sel_half;
	logic [word_width-1:0] left_word;
	logic [word_width-1:0] left_mask;
	logic [word_width-1:0] right_word;
	logic [word_width-1:0] right_mask;

	// selected byte or halfword brought down to bit 0
	assign byte_shifted = load_word >> {fmt.offset, 3'b000};
	assign half_shifted = load_word >> {fmt.offset[1], 4'b0000};
	assign sel_byte = byte_shifted[7:0];
	assign sel_half = half_shifted[15:0];

	// LWL: memory bytes 0..offset land in result bytes 3-offset..3
	// shift by 3-offset bytes, which is ~offset for two bits
	assign left_word = load_word << {~fmt.offset, 3'b000};
	assign left_mask = {word_width{1'b1}} << {~fmt.offset, 3'b000};

	// LWR: memory bytes offset..3 land in result bytes 0..3-offset
	assign right_word = load_word >> {fmt.offset, 3'b000};
	assign right_mask = {word_width{1'b1}} >> {fmt.offset, 3'b000};

	always_comb begin
		case (fmt.op)
			op_lb: begin
				load_data = {{(word_width-8){sel_byte[7]}}, sel_byte};
			end
			op_lbu: begin
				load_data = {{(word_width-8){1'b0}}, sel_byte};
			end
			op_lh: begin
				load_data = {{(word_width-16){sel_half[15]}}, sel_half};
			end
			op_lhu: begin
				load_data = {{(word_width-16){1'b0}}, sel_half};
			end
			op_lwl: begin
				load_data = left_word | (rt_value & ~left_mask);
			end
			op_lwr: begin
				load_data = right_word | (rt_value & ~right_mask);
			end
			// LW and anything else: whole word
			default: begin
				load_data = load_word;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/mem_req_if.sv ====
// ========================================
// latched data request and its lane decode
// addr_width must be 3 or more
// ========================================
`default_nettype none

interface mem_req_if
	import mips_bus_pkg::*;
#(
	parameter int addr_width = 32
);

	logic [op_width-1:0]   op;
	logic [1:0]            offset;
	logic [word_width-1:0] store_data;
	logic [lane_count-1:0] byteenable;
	logic [word_width-1:0] writedata;

	// word address needs at least one bit above the byte offset
	if (addr_width < 3) begin : g_width_check
		$error("mem_req_if: addr_width must be 3 or more");
	end

	modport seq (
		output op, offset, store_data,
		input  byteenable, writedata
	);

	modport lanes (
		input  op, offset, store_data,
		output byteenable, writedata
	);

	modport fmt (
		input op, offset
	);

endinterface

`default_nettype wire

// ==== verilog/mips_bus_pkg.sv ====
// ========================================
// widths, MIPS load/store opcodes and lane masks
// opcodes are the 6-bit major opcode field
// ========================================
`default_nettype none

package mips_bus_pkg;

	// data path
	localparam int word_width = 32;
	localparam int lane_count = 4;

	// memory opcode field
	localparam int op_width = 6;

	// loads
	localparam logic [op_width-1:0] op_lb  = 6'h20;
	localparam logic [op_width-1:0] op_lh  = 6'h21;
	localparam logic [op_width-1:0] op_lwl = 6'h22;
	localparam logic [op_width-1:0] op_lw  = 6'h23;
	localparam logic [op_width-1:0] op_lbu = 6'h24;
	localparam logic [op_width-1:0] op_lhu = 6'h25;
	localparam logic [op_width-1:0] op_lwr = 6'h26;

	// stores
	localparam logic [op_width-1:0] op_sb  = 6'h28;
	localparam logic [op_width-1:0] op_sh  = 6'h29;
	localparam logic [op_width-1:0] op_sw  = 6'h2B;

	// byteenable, active high
	localparam logic [lane_count-1:0] lanes_all = 4'b1111;

endpackage

`default_nettype wire

// ==== verilog/mips_bus_port.sv ====
// ========================================
// Avalon master for one fetch plus optional load/store per step
// request inputs sampled only when step and ready are both high
// ========================================
`default_nettype none

module mips_bus_port
	import mips_bus_pkg::*;
#(
	parameter int addr_width = 32
) (
	input  logic                  clk,
	input  logic                  reset,

	// request
	input  logic                  step,
	input  logic [addr_width-1:0] pc,
	input  logic                  mem_en,
	input  logic [op_width-1:0]   op,
	input  logic [addr_width-1:0] data_addr,
	input  logic [word_width-1:0] store_data,
	input  logic [word_width-1:0] rt_value,

	// status and results
	output logic                  ready,
	output logic                  done,
	output logic [word_width-1:0] instruction,
	output logic [word_width-1:0] load_data,

	// Avalon master
	output logic [addr_width-1:0] address,
	output logic                  read,
	output logic                  write,
	input  logic                  waitrequest,
	output logic [word_width-1:0] writedata,
	output logic [lane_count-1:0] byteenable,
	input  logic [word_width-1:0] readdata
);

	logic [word_width-1:0] load_word;
	logic [word_width-1:0] rt_held;

	mem_req_if #(.addr_width(addr_width)) req_bus ();

	access_sequencer #(.addr_width(addr_width)) u_sequencer (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.pc          (pc),
		.mem_en      (mem_en),
		.op          (op),
		.data_addr   (data_addr),
		.store_data  (store_data),
		.rt_value    (rt_value),
		.ready       (ready),
		.done        (done),
		.address     (address),
		.read        (read),
		.write       (write),
		.waitrequest (waitrequest),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.readdata    (readdata),
		.instruction (instruction),
		.load_word   (load_word),
		.rt_held     (rt_held),
		.req         (req_bus.seq)
	);

	lane_decoder u_lanes (
		.lanes (req_bus.lanes)
	);

	load_formatter u_formatter (
		.fmt       (req_bus.fmt),
		.load_word (load_word),
		.rt_value  (rt_held),
		.load_data (load_data)
	);

endmodule

`default_nettype wire
